/* video_playfield.f */
+incdir+source
source/vid_types_pkg.sv
source/pf_mode_pkg.sv
source/pf_words_if.sv
source/pf_line_addr.sv
source/pf_fetch.sv
source/pf_expand.sv
source/pf_scanout.sv
source/video_playfield.sv
verif/tb_video_playfield.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_video_playfield
FILELIST  ?= video_playfield.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/tb_video_playfield.sv */
//==============================
// playfield testbench, vram model returns {addr[7:0], ~addr[7:0]}
// first group of each window is not checked, it may be left from the last line
// repeat frames keep addresses in 0x80..0xfe so neighbor pixels differ
//==============================
`timescale 1ns/10ps
`include "pf_settings.svh"

module tb_video_playfield;

    localparam int LINE_LEN    = 400;
    localparam int LINES       = 6;
    localparam int FRAMES      = 8;
    localparam int FETCH_FIRST = 150;
    localparam int FETCH_LAST  = 380;
    localparam int WIN_FIRST   = `PF_SCANOUT_BEGIN + 1;     // first sample of pixel 0
    localparam int WIN_LAST    = `PF_SCANOUT_BEGIN + 160;
    localparam int MAX_CYCLES  = FRAMES * LINES * LINE_LEN + 1000;

    logic clk, reset_i, mem_fetch_i, mem_fetch_start_i;
    logic end_of_line_i, end_of_frame_i, pf_blank_i;
    vid_types_pkg::hres_t   h_count_i, vid_left_i, vid_right_i;
    vid_types_pkg::color_t  border_color_i, pf_colorbase_i, pf_color_index_o;
    vid_types_pkg::word_t   vram_data_i, pf_line_len_i;
    vid_types_pkg::addr_t   pf_start_addr_i, vram_addr_o, rd_addr, last_addr, exp_addr;
    vid_types_pkg::addr_t   grp_addr;                           // first word of sampled group
    logic [1:0]             pf_bpp_i;
    vid_types_pkg::repeat_t pf_h_repeat_i, pf_v_repeat_i;
    logic                   vram_sel_o, rd_pend, first_pending, pre_frame, running;
    vid_types_pkg::pixels_t grp, grp_exp;
    logic                   grp_done, run_done, in_border;
    logic [7:0]             run_val;
    int                     run_len, run_start, run_prev, cur_line, cycles;
    int                     errs [5];

    video_playfield uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // group of eight indices as the memory model and expand rules give it
    function automatic vid_types_pkg::pixels_t exp_group(logic [1:0] bpp, logic [7:0] a);
        vid_types_pkg::pixels_t p;
        logic [7:0]             b;
        logic [15:0]            w;
        for (int i = 0; i < 8; i++) begin
            case (bpp)
                2'd0: p[63-8*i -: 8] = {4'h0, ~a[7-i] ? a[7:4] : a[3:0]};  // attr = word0
                2'd1: begin
                    b = a + 8'(i / 4);
                    w = {b, ~b};
                    p[63-8*i -: 8] = {4'h0, w[15-4*(i%4) -: 4]};
                end
                default: begin
                    b = a + 8'(i / 2);
                    p[63-8*i -: 8] = (i % 2 == 0) ? b : ~b;          // high byte first
                end
            endcase
        end
        return p;
    endfunction

    // first word of window group g
    // an 8 bpp group 0 is still in flight at scanout start
    function automatic vid_types_pkg::addr_t group_addr(logic [1:0] bpp,
            vid_types_pkg::addr_t line_start, int g);
        case (bpp)
            2'd0: return line_start + 16'(g);                       // one word per group
            2'd1: return line_start + 16'(2 * g);
            default: return line_start + 16'(4 * (g - 1));         // window opens a group late
        endcase
    endfunction

    function automatic vid_types_pkg::addr_t line_start_exp(vid_types_pkg::addr_t start,
            vid_types_pkg::word_t len, vid_types_pkg::repeat_t v_rep, int line);
        return start + len * 16'(line / (int'(v_rep) + 1));
    endfunction

    // vram, data one cycle after the select
    always @(posedge clk) begin
        rd_pend <= vram_sel_o;
        rd_addr <= vram_addr_o;
    end
    always @(negedge clk) begin
        if (rd_pend) vram_data_i = {rd_addr[7:0], ~rd_addr[7:0]};
    end

    always @(posedge clk) begin
        if (reset_i) begin
            first_pending <= 1'b0;
        end else begin
            if (vram_sel_o) begin
                first_pending   <= 1'b0;
                last_addr       <= vram_addr_o;
            end
            if (mem_fetch_start_i) first_pending <= 1'b1;           // next read opens the line
        end
    end

    assign exp_addr = first_pending ?
        line_start_exp(pf_start_addr_i, pf_line_len_i, pf_v_repeat_i, cur_line) :
        last_addr + 1'b1;
    assign grp_exp   = exp_group(pf_bpp_i, grp_addr[7:0]);
    assign in_border = running && ((h_count_i >= FETCH_FIRST && h_count_i < WIN_FIRST)
                                   || h_count_i > WIN_LAST);

    // window sampler, groups of eight and runs of equal indices
    always @(posedge clk) begin
        int         pos;
        logic [7:0] pix;
        pos = int'(h_count_i) - WIN_FIRST;
        pix = pf_color_index_o ^ pf_colorbase_i;
        grp_done <= 1'b0;
        run_done <= 1'b0;
        if (running && pos >= 0 && pos <= WIN_LAST - WIN_FIRST) begin
            grp      <= {grp[55:0], pix};
            grp_done <= (pos % 8 == 7) && (pos >= 8);               // skip group 0
            grp_addr <= group_addr(pf_bpp_i, line_start_exp(pf_start_addr_i, pf_line_len_i,
                                   pf_v_repeat_i, cur_line), pos / 8);
            if (pos == 0 || pix != run_val) begin
                run_done  <= (pos != 0) && (run_start >= 8 * 3);
                run_prev  <= run_len;
                run_val   <= pix;
                run_len   <= 1;
                run_start <= pos;
            end else begin
                run_len   <= run_len + 1;
            end
        end
    end

    assert property (@(posedge clk) pre_frame |-> !vram_sel_o)
        else begin errs[0]++; $display("error reset_sel expected 0 actual 1"); end
    assert property (@(posedge clk) pre_frame |-> pf_color_index_o == pf_colorbase_i)
        else begin
            errs[0]++;
            $display("error reset_color expected %h actual %h",
                     $sampled(pf_colorbase_i), $sampled(pf_color_index_o));
        end
    assert property (@(posedge clk) disable iff (reset_i || !running)
                     vram_sel_o |-> vram_addr_o == exp_addr)
        else begin
            errs[1]++;
            $display("error address expected %h actual %h",
                     $sampled(exp_addr), $sampled(vram_addr_o));
        end
    assert property (@(posedge clk) (grp_done && pf_h_repeat_i == 2'd0) |-> grp == grp_exp)
        else begin
            errs[2]++;
            $display("error pixels bpp %0d expected %h actual %h",
                     $sampled(pf_bpp_i), $sampled(grp_exp), $sampled(grp));
        end
    assert property (@(posedge clk) in_border |->
                     pf_color_index_o == (border_color_i ^ pf_colorbase_i))
        else begin
            errs[3]++;
            $display("error border expected %h actual %h",
                     $sampled(border_color_i ^ pf_colorbase_i), $sampled(pf_color_index_o));
        end
    assert property (@(posedge clk) (run_done && pf_h_repeat_i == 2'd2) |-> run_prev == 3)
        else begin errs[4]++; $display("error h_repeat expected 3 actual %0d", $sampled(run_prev)); end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout, run stopped after %0d cycles", cycles);
            $display("test failed");
            $finish;
        end
    end

    task automatic run_frame(input logic [1:0] bpp, input vid_types_pkg::repeat_t h_rep,
            input vid_types_pkg::repeat_t v_rep, input vid_types_pkg::word_t len,
            input vid_types_pkg::addr_t start, input logic blank);
        for (int line = 0; line < LINES; line++) begin
            for (int h = 0; h < LINE_LEN; h++) begin
                @(negedge clk);
                if (line == 0 && h == 0) begin                      // unchanged unless blanked
                    pf_bpp_i        = bpp;
                    pf_h_repeat_i   = h_rep;
                    pf_v_repeat_i   = v_rep;
                    pf_line_len_i   = len;
                    pf_start_addr_i = start;
                    pf_colorbase_i  = 8'($urandom);
                    border_color_i  = 8'($urandom);
                    running         = 1'b1;
                end
                cur_line          = line;
                h_count_i         = 11'(h);
                mem_fetch_i       = (h >= FETCH_FIRST && h <= FETCH_LAST);
                mem_fetch_start_i = (h == FETCH_FIRST - 1);
                end_of_line_i     = (h == LINE_LEN - 1);
                end_of_frame_i    = end_of_line_i && (line == LINES - 1);
                pf_blank_i        = blank && (line == 0 && h == 0);
            end
        end
    endtask

    initial begin
        int                     total;
        vid_types_pkg::repeat_t v_rep;
        vid_types_pkg::word_t   len;
        vid_types_pkg::addr_t   start;
        void'($urandom(32'hae5));
        {reset_i, pre_frame, running} = 3'b100;
        {mem_fetch_i, mem_fetch_start_i, end_of_line_i, end_of_frame_i, pf_blank_i} = '0;
        h_count_i = '0;
        vid_left_i = 11'd0;
        vid_right_i = 11'd160;
        vram_data_i = '0;
        pf_bpp_i = 2'd2;
        {pf_h_repeat_i, pf_v_repeat_i} = '0;
        pf_line_len_i = 16'd32;
        pf_start_addr_i = '0;
        pf_colorbase_i = 8'($urandom);
        border_color_i = 8'($urandom);
        cur_line = 0;
        cycles = 0;
        repeat (5) @(negedge clk);
        reset_i = 1'b0;
        pre_frame = 1'b1;                                           // idle before any frame
        repeat (10) @(negedge clk);
        pre_frame = 1'b0;
        for (int m = 0; m < 3; m++) begin                           // 8, 4 then 1 bpp
            v_rep = 2'($urandom);
            len   = 16'($urandom);
            start = 16'($urandom);
            run_frame(2'(2 - m), 2'd0, v_rep, len, start, 1'b1);
            run_frame(2'(2 - m), 2'd0, v_rep, len, start, 1'b0);    // end of frame restarts
        end
        len   = 16'($urandom % 16 + 1);
        start = {8'($urandom), 8'h80};
        run_frame(2'd2, 2'd2, 2'd0, len, start, 1'b1);
        run_frame(2'd2, 2'd2, 2'd0, len, start, 1'b0);
        @(negedge clk);
        total = errs[0] + errs[1] + errs[2] + errs[3] + errs[4];
        $display("errors: reset %0d address %0d pixels %0d border %0d repeat %0d total %0d",
                 errs[0], errs[1], errs[2], errs[3], errs[4], total);
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* source/video_playfield.sv */
//==============================
// bitmap playfield, one plane
// vram read data expected one cycle after vram_sel_o
//==============================
`timescale 1ns/10ps

module video_playfield (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   mem_fetch_i,
    input  wire logic                   mem_fetch_start_i,
    input  wire logic                   end_of_line_i,
    input  wire logic                   end_of_frame_i,
    input  wire logic                   pf_blank_i,
    input  wire vid_types_pkg::hres_t   h_count_i,
    input  wire vid_types_pkg::hres_t   vid_left_i,
    input  wire vid_types_pkg::hres_t   vid_right_i,
    input  wire vid_types_pkg::color_t  border_color_i,
    input  wire vid_types_pkg::color_t  pf_colorbase_i,
    input  wire vid_types_pkg::word_t   vram_data_i,
    input  wire vid_types_pkg::word_t   pf_line_len_i,
    input  wire vid_types_pkg::addr_t   pf_start_addr_i,
    input  wire logic [1:0]             pf_bpp_i,
    input  wire vid_types_pkg::repeat_t pf_h_repeat_i,
    input  wire vid_types_pkg::repeat_t pf_v_repeat_i,
    output      logic                   vram_sel_o,
    output      vid_types_pkg::addr_t   vram_addr_o,
    output      vid_types_pkg::color_t  pf_color_index_o
);

    pf_mode_pkg::bpp_t      bpp;
    vid_types_pkg::addr_t   line_start_addr;
    vid_types_pkg::pixels_t buf_pixels;
    logic                   take;

    assign bpp = pf_mode_pkg::bpp_t'(pf_bpp_i);

    pf_words_if words ();

    pf_line_addr u_line_addr (
        .clk, .reset_i, .end_of_line_i, .end_of_frame_i, .pf_blank_i,
        .pf_start_addr_i, .pf_line_len_i, .pf_v_repeat_i,
        .line_start_addr_o  (line_start_addr)
    );

    pf_fetch u_fetch (
        .clk, .reset_i, .mem_fetch_i, .mem_fetch_start_i, .end_of_line_i,
        .end_of_frame_i, .pf_blank_i,
        .pf_bpp_i           (bpp),
        .line_start_addr_i  (line_start_addr),
        .pf_start_addr_i, .vram_data_i, .vram_sel_o, .vram_addr_o,
        .words              (words.fetch_mp)
    );

    pf_expand u_expand (
        .clk, .reset_i, .mem_fetch_start_i,
        .take_i             (take),
        .pf_bpp_i           (bpp),
        .words              (words.expand_mp),
        .buf_pixels_o       (buf_pixels)
    );

    pf_scanout u_scanout (
        .clk, .reset_i, .mem_fetch_i, .mem_fetch_start_i, .end_of_line_i,
        .h_count_i, .vid_left_i, .vid_right_i, .border_color_i, .pf_colorbase_i,
        .pf_h_repeat_i,
        .buf_pixels_i       (buf_pixels),
        .take_o             (take),
        .pf_color_index_o
    );

endmodule

/* source/pf_scanout.sv */
//==============================
// scanout window, h repeat and pixel shifter
// window edges relative to PF_SCANOUT_BEGIN
// border shown outside window from line fetch start
//==============================
`timescale 1ns/10ps
`include "pf_settings.svh"

module pf_scanout (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   mem_fetch_i,
    input  wire logic                   mem_fetch_start_i,
    input  wire logic                   end_of_line_i,
    input  wire vid_types_pkg::hres_t   h_count_i,
    input  wire vid_types_pkg::hres_t   vid_left_i,
    input  wire vid_types_pkg::hres_t   vid_right_i,
    input  wire vid_types_pkg::color_t  border_color_i,
    input  wire vid_types_pkg::color_t  pf_colorbase_i,
    input  wire vid_types_pkg::repeat_t pf_h_repeat_i,
    input  wire vid_types_pkg::pixels_t buf_pixels_i,
    output      logic                   take_o,             // buffer loaded into shifter
    output      vid_types_pkg::color_t  pf_color_index_o
);

    vid_types_pkg::hres_t   start_hcount;
    vid_types_pkg::hres_t   end_hcount;
    logic                   scanout;                        // inside window
    logic                   scanout_start;
    logic                   scanout_end;
    vid_types_pkg::repeat_t h_cnt;                          // repeat countdown
    logic [2:0]             tile_x;                         // pixel within group
    vid_types_pkg::pixels_t pixels;                         // shifter, msb out

    assign start_hcount  = vid_types_pkg::hres_t'(`PF_SCANOUT_BEGIN) + vid_left_i;
    assign end_hcount    = vid_types_pkg::hres_t'(`PF_SCANOUT_BEGIN) + vid_right_i;
    assign scanout_start = (h_count_i == start_hcount) && mem_fetch_i;
    assign scanout_end   = (h_count_i == end_hcount) || end_of_line_i;
    assign take_o        = scanout_start || (scanout && h_cnt == '0 && tile_x == 3'd7);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            scanout <= 1'b0;
            h_cnt   <= '0;
            tile_x  <= '0;
            pixels  <= '0;
        end else begin
            if (scanout) begin
                if (h_cnt != '0) begin
                    h_cnt   <= h_cnt - 1'b1;                // hold pixel
                end else begin
                    h_cnt   <= pf_h_repeat_i;
                    tile_x  <= tile_x + 1'b1;
                    if (tile_x == 3'd7) pixels <= buf_pixels_i;     // next group
                    else pixels <= {pixels[7*`PF_COLOR_W-1:0], border_color_i};
                end
            end
            if (mem_fetch_start_i) pixels[8*`PF_COLOR_W-1 -: `PF_COLOR_W] <= border_color_i;
            if (scanout_start) begin
                scanout <= 1'b1;
                tile_x  <= '0;
                h_cnt   <= pf_h_repeat_i;
                pixels  <= buf_pixels_i;                    // first group of line
            end
            if (scanout_end) begin
                scanout <= 1'b0;
                pixels[8*`PF_COLOR_W-1 -: `PF_COLOR_W] <= border_color_i;
            end
        end
    end

    assign pf_color_index_o = pixels[8*`PF_COLOR_W-1 -: `PF_COLOR_W] ^ pf_colorbase_i;

endmodule

/* source/pf_expand.sv */
//==============================
// word group to eight color indices
// buffer holds until scanout takes it
//==============================
`timescale 1ns/10ps
`include "pf_settings.svh"

module pf_expand (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   mem_fetch_start_i,
    input  wire logic                   take_i,         // scanout loaded the buffer
    input  wire pf_mode_pkg::bpp_t      pf_bpp_i,
    pf_words_if.expand_mp               words,
    output      vid_types_pkg::pixels_t buf_pixels_o
);

    logic [3:0]             fore;
    logic [3:0]             back;               // also upper nibble extension
    logic [31:0]            nibbles;            // 4 bpp data
    vid_types_pkg::pixels_t bytes;              // 8 bpp data
    vid_types_pkg::pixels_t pixels_next;

    assign fore     = words.attr[pf_mode_pkg::ATTR_FORE +: 4];
    assign back     = words.attr[pf_mode_pkg::ATTR_BACK +: 4];
    assign nibbles  = {words.word0, words.word1};
    assign bytes    = {words.word0, words.word1, words.word2, words.word3};

    always_comb begin
        for (int i = 0; i < 8; i++) begin       // pixel 0 goes to the msb
            case (pf_bpp_i)
                pf_mode_pkg::BPP_1_ATTR:
                    pixels_next[63-8*i -: 8] = {4'h0, words.word0[7-i] ? fore : back};
                pf_mode_pkg::BPP_4:
                    pixels_next[63-8*i -: 8] = {back, nibbles[31-4*i -: 4]};
                default:
                    pixels_next[63-8*i -: 8] = bytes[63-8*i -: 8] ^ {back, 4'h0};
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            words.buffer_full <= 1'b0;
        end else if (mem_fetch_start_i) begin
            words.buffer_full <= 1'b0;          // new line, drop leftovers
        end else if (words.words_ready) begin
            words.buffer_full <= 1'b1;
        end else if (take_i) begin
            words.buffer_full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (words.words_ready) buf_pixels_o <= pixels_next;
    end

endmodule

/* source/pf_fetch.sv */
//==============================
// bitmap vram fetch, 1, 2 or 4 words per group
// read data valid one cycle after vram_sel_o
// up to two reads outstanding
//==============================
`timescale 1ns/10ps

module pf_fetch (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   mem_fetch_i,        // fetch window
    input  wire logic                   mem_fetch_start_i,  // line fetch start strobe
    input  wire logic                   end_of_line_i,
    input  wire logic                   end_of_frame_i,
    input  wire logic                   pf_blank_i,
    input  wire pf_mode_pkg::bpp_t      pf_bpp_i,
    input  wire vid_types_pkg::addr_t   line_start_addr_i,
    input  wire vid_types_pkg::addr_t   pf_start_addr_i,
    input  wire vid_types_pkg::word_t   vram_data_i,
    output      logic                   vram_sel_o,
    output      vid_types_pkg::addr_t   vram_addr_o,
    pf_words_if.fetch_mp                words
);

    pf_mode_pkg::fetch_st_t state, state_next;
    vid_types_pkg::addr_t   pf_addr;            // next display word
    logic                   issue;              // put pf_addr on the bus
    logic                   ready_next;
    logic                   initial_buf;        // first group of line not yet started
    logic                   one_bpp;

    assign one_bpp = (pf_bpp_i == pf_mode_pkg::BPP_1_ATTR);

    always_comb begin
        state_next  = state;
        issue       = 1'b0;
        ready_next  = 1'b0;
        case (state)
            pf_mode_pkg::FETCH_IDLE: begin
                if (mem_fetch_i) state_next = pf_mode_pkg::FETCH_ADDR;
            end
            pf_mode_pkg::FETCH_ADDR: begin
                if (!mem_fetch_i) begin
                    state_next  = pf_mode_pkg::FETCH_IDLE;
                end else if (!words.buffer_full) begin
                    issue       = 1'b1;                         // word 0 out
                    state_next  = pf_mode_pkg::FETCH_WAIT;
                end
            end
            pf_mode_pkg::FETCH_WAIT: begin
                issue       = !one_bpp;                         // word 1 out
                ready_next  = !initial_buf;                     // previous group still held
                state_next  = pf_mode_pkg::FETCH_READ_0;
            end
            pf_mode_pkg::FETCH_READ_0: begin
                issue       = !one_bpp && (pf_bpp_i != pf_mode_pkg::BPP_4);    // word 2 out
                state_next  = one_bpp ? pf_mode_pkg::FETCH_ADDR : pf_mode_pkg::FETCH_READ_1;
            end
            pf_mode_pkg::FETCH_READ_1: begin
                issue       = (pf_bpp_i != pf_mode_pkg::BPP_4); // word 3 out
                state_next  = issue ? pf_mode_pkg::FETCH_READ_2 : pf_mode_pkg::FETCH_ADDR;
            end
            pf_mode_pkg::FETCH_READ_2: state_next = pf_mode_pkg::FETCH_READ_3;
            pf_mode_pkg::FETCH_READ_3: state_next = pf_mode_pkg::FETCH_ADDR;
            default: state_next = pf_mode_pkg::FETCH_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state               <= pf_mode_pkg::FETCH_IDLE;
            vram_sel_o          <= 1'b0;
            vram_addr_o         <= '0;
            pf_addr             <= '0;
            initial_buf         <= 1'b0;
            words.words_ready   <= 1'b0;
        end else begin
            state               <= state_next;
            vram_sel_o          <= issue;
            words.words_ready   <= ready_next;
            if (issue) begin
                vram_addr_o <= pf_addr;
                pf_addr     <= pf_addr + 1'b1;              // consecutive words
            end
            if (state == pf_mode_pkg::FETCH_WAIT) initial_buf <= 1'b0;
            if (mem_fetch_start_i) initial_buf <= 1'b1;
            if (mem_fetch_start_i || end_of_line_i) pf_addr <= line_start_addr_i;
            if (end_of_frame_i || pf_blank_i) pf_addr <= pf_start_addr_i;
        end
    end

    // word capture, two cycles after each address
    always_ff @(posedge clk) begin
        case (state)
            pf_mode_pkg::FETCH_READ_0: begin
                words.word0 <= vram_data_i;
                words.attr  <= one_bpp ? vram_data_i : '0;  // no color extension above 1 bpp
            end
            pf_mode_pkg::FETCH_READ_1: words.word1 <= vram_data_i;
            pf_mode_pkg::FETCH_READ_2: words.word2 <= vram_data_i;
            pf_mode_pkg::FETCH_READ_3: words.word3 <= vram_data_i;
            default: ;
        endcase
    end

endmodule

/* source/pf_line_addr.sv */
//==============================
// line start address and vertical repeat
// frame restart and blank win over end of line
//==============================
`timescale 1ns/10ps

module pf_line_addr (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   end_of_line_i,
    input  wire logic                   end_of_frame_i,
    input  wire logic                   pf_blank_i,
    input  wire vid_types_pkg::addr_t   pf_start_addr_i,    // frame start
    input  wire vid_types_pkg::word_t   pf_line_len_i,      // words per line
    input  wire vid_types_pkg::repeat_t pf_v_repeat_i,
    output      vid_types_pkg::addr_t   line_start_addr_o
);

    vid_types_pkg::repeat_t v_count;                        // lines left on this address
    vid_types_pkg::addr_t   line_start;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            v_count     <= '0;
            line_start  <= '0;
        end else if (end_of_frame_i || pf_blank_i) begin
            v_count     <= pf_v_repeat_i;                   // restart at top of frame
            line_start  <= pf_start_addr_i;
        end else if (end_of_line_i) begin
            if (v_count != '0) begin
                v_count     <= v_count - 1'b1;              // repeat same line
            end else begin
                v_count     <= pf_v_repeat_i;
                line_start  <= line_start + pf_line_len_i;  // step to next line
            end
        end
    end

    assign line_start_addr_o = line_start;

endmodule

/* source/pf_words_if.sv */
//==============================
// one fetched word group, fetch to expand
// words_ready announces the group held before the current fetch
//==============================
`timescale 1ns/10ps

interface pf_words_if;

    logic                   words_ready;    // one cycle strobe
    vid_types_pkg::word_t   word0;
    vid_types_pkg::word_t   word1;
    vid_types_pkg::word_t   word2;
    vid_types_pkg::word_t   word3;
    vid_types_pkg::word_t   attr;           // zero outside 1 bpp
    logic                   buffer_full;    // level, holds the fetch machine

    modport fetch_mp (output words_ready, word0, word1, word2, word3, attr,
                      input  buffer_full);
    modport expand_mp (input  words_ready, word0, word1, word2, word3, attr,
                       output buffer_full);

endinterface

/* source/pf_mode_pkg.sv */
//==============================
// playfield mode encodings
// BPP_XX is decoded as 8 bpp
//==============================
package pf_mode_pkg;

    typedef enum logic [1:0] {
        BPP_1_ATTR  = 2'd0,         // 1 bpp, attribute in high byte
        BPP_4       = 2'd1,
        BPP_8       = 2'd2,
        BPP_XX      = 2'd3          // reserved, same as 8 bpp
    } bpp_t;

    typedef enum logic [2:0] {
        FETCH_IDLE,                 // outside fetch window
        FETCH_ADDR,                 // first address out, or held by full buffer
        FETCH_WAIT,                 // first read in flight
        FETCH_READ_0,
        FETCH_READ_1,
        FETCH_READ_2,
        FETCH_READ_3
    } fetch_st_t;

    localparam int ATTR_FORE = 12;  // foreground nibble position
    localparam int ATTR_BACK = 8;   // background nibble, also color extension

endpackage

/* source/vid_types_pkg.sv */
//==============================
// vector types shared by the video path
// widths come from pf_settings.svh
//==============================
`include "pf_settings.svh"

package vid_types_pkg;

    typedef logic [`PF_WORD_W-1:0]      word_t;         // vram data word
    typedef logic [`PF_ADDR_W-1:0]      addr_t;         // vram word address
    typedef logic [`PF_COLOR_W-1:0]     color_t;        // color index
    typedef logic [`PF_HRES_W-1:0]      hres_t;         // horizontal count
    typedef logic [8*`PF_COLOR_W-1:0]   pixels_t;       // eight indices, first pixel in msb
    typedef logic [1:0]                 repeat_t;       // pixel repeat minus one

endpackage

/* source/pf_settings.svh */
//==============================
// fixed widths of the playfield register map
// scanout begins two counts ahead of the first visible pixel
//==============================
`ifndef PF_SETTINGS_SVH
`define PF_SETTINGS_SVH

`define PF_WORD_W           16                          // vram data word
`define PF_ADDR_W           16                          // vram word address
`define PF_COLOR_W          8                           // color index
`define PF_HRES_W           11                          // horizontal count
`define PF_OFFSCREEN_W      160                         // h count of first visible pixel
`define PF_SCANOUT_BEGIN    (`PF_OFFSCREEN_W - 2)       // shifter pipeline lead

`endif
